//--- Bender.yml
package:
  name: autotest

sources:
  - src/autotest_cfg_pkg.sv
  - src/autotest_state_pkg.sv
  - src/run_timer.sv
  - src/block_buffer.sv
  - src/test_vector_regs.sv
  - src/result_writer.sv
  - src/autotest_fsm.sv
  - src/autotest_top.sv
  - target: test
    files:
      - testbench/sd_card_model.sv
      - testbench/tb_autotest.sv

//--- src/autotest_cfg_pkg.sv
//##########################################################
// block layout and constants of the SD self-test sequencer.
// shared by the RTL and the testbench through scoped names.
//##########################################################

package autotest_cfg_pkg;

  // SD block and byte index
  localparam int BLOCK_BYTES = 512;
  localparam int BYTE_IDX_W  = 9;

  // header holds the signature then the UUT input word
  localparam int          SIG_BYTES = 4;
  localparam logic [31:0] SIGNATURE = 32'hAABB_CCDD;
  localparam int          IN_BYTES  = 4;
  localparam int          IN_W      = 8 * IN_BYTES;
  localparam int          IN_OFS    = 4;

  // write-back fields go least significant byte first
  localparam int RESULT_OFS   = 8;
  localparam int RESULT_BYTES = 4;
  localparam int TIME_OFS     = 12;
  localparam int TIME_W       = 64;

  localparam logic [31:0] START_BLOCK = 32'h0010_0000;

  // kept short so a hung UUT stays cheap to simulate
  localparam int TIMEOUT_CYCLES = 4096;

  localparam int ERR_CNT_W = 32;

endpackage

//--- src/autotest_fsm.sv
//##########################################################
// sequencer FSM: SD host strobes, UUT control, block address
// and the enables of the data path. outputs decode the state.
//##########################################################

`timescale 1ns/10ps

module autotest_fsm (
  input  logic        clk,
  input  logic        rst,
  input  logic        spi_busy_i,
  input  logic        end_uut_i,
  input  logic        err_uut_i,
  input  logic        last_byte_i,
  input  logic        sig_match_i,
  input  logic        timeout_i,
  output logic        spi_rst_o,
  output logic        spi_r_block_o,
  output logic        spi_r_byte_o,
  output logic        spi_w_block_o,
  output logic        spi_w_byte_o,
  output logic [31:0] spi_block_addr_o,
  output logic        rst_uut_o,
  output logic        start_uut_o,
  output logic        ctrl_mux_uut_o,
  output logic        done_o,
  output logic        idx_clr_o,
  output logic        idx_inc_o,
  output logic        mem_we_o,
  output logic        cap_clr_o,
  output logic        cap_en_o,
  output logic        timer_clr_o,
  output logic        timer_run_o,
  output logic        result_store_o,
  output logic        wdata_load_o
);

  logic [autotest_state_pkg::STATE_W-1:0] state;
  logic [autotest_state_pkg::STATE_W-1:0] next_state;
  logic [31:0] blk_addr;
  logic        blk_inc;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= autotest_state_pkg::S_INIT;
    end else begin
      state <= next_state;
    end
  end

  // same address serves the read and the write-back of a block
  always_ff @(posedge clk) begin
    if (state == autotest_state_pkg::S_INIT) begin
      blk_addr <= autotest_cfg_pkg::START_BLOCK;
    end else if (blk_inc) begin
      blk_addr <= blk_addr + 32'd1;
    end
  end

  assign spi_block_addr_o = blk_addr;

  always_comb begin
    next_state     = state;
    spi_rst_o      = 1'b0;
    spi_r_block_o  = 1'b0;
    spi_r_byte_o   = 1'b0;
    spi_w_block_o  = 1'b0;
    spi_w_byte_o   = 1'b0;
    rst_uut_o      = 1'b0;
    start_uut_o    = 1'b0;
    ctrl_mux_uut_o = 1'b0;
    done_o         = 1'b0;
    idx_clr_o      = 1'b0;
    idx_inc_o      = 1'b0;
    mem_we_o       = 1'b0;
    cap_clr_o      = 1'b0;
    cap_en_o       = 1'b0;
    timer_clr_o    = 1'b0;
    timer_run_o    = 1'b0;
    result_store_o = 1'b0;
    wdata_load_o   = 1'b0;
    blk_inc        = 1'b0;

    case (state)
      autotest_state_pkg::S_INIT: begin
        next_state = autotest_state_pkg::S_SPI_RST;
      end
      autotest_state_pkg::S_SPI_RST: begin
        rst_uut_o = 1'b1;
        spi_rst_o = 1'b1;
        if (spi_busy_i) next_state = autotest_state_pkg::S_WAIT_RST;
      end
      autotest_state_pkg::S_WAIT_RST: begin
        rst_uut_o = 1'b1;
        if (!spi_busy_i) next_state = autotest_state_pkg::S_IDLE;
      end
      autotest_state_pkg::S_IDLE: begin
        rst_uut_o   = 1'b1;
        idx_clr_o   = 1'b1;
        cap_clr_o   = 1'b1;
        timer_clr_o = 1'b1;
        if (!spi_busy_i) next_state = autotest_state_pkg::S_RD_BLOCK;
      end
      autotest_state_pkg::S_RD_BLOCK: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        if (spi_busy_i) next_state = autotest_state_pkg::S_WAIT_RD_BLOCK;
      end
      autotest_state_pkg::S_WAIT_RD_BLOCK: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        if (!spi_busy_i) next_state = autotest_state_pkg::S_RD_DATA;
      end
      autotest_state_pkg::S_RD_DATA: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        next_state    = autotest_state_pkg::S_RD_BYTE;
      end
      autotest_state_pkg::S_RD_BYTE: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        spi_r_byte_o  = 1'b1;
        if (spi_busy_i) next_state = autotest_state_pkg::S_WAIT_RD_BYTE;
      end
      autotest_state_pkg::S_WAIT_RD_BYTE: begin
        rst_uut_o     = 1'b1;
        spi_r_block_o = 1'b1;
        // byte valid on the busy fall
        if (!spi_busy_i) begin
          mem_we_o   = 1'b1;
          cap_en_o   = 1'b1;
          idx_inc_o  = 1'b1;
          next_state = last_byte_i ? autotest_state_pkg::S_CHECK_SIG
                                   : autotest_state_pkg::S_RD_DATA;
        end
      end
      autotest_state_pkg::S_CHECK_SIG: begin
        rst_uut_o  = 1'b1;
        next_state = sig_match_i ? autotest_state_pkg::S_START
                                 : autotest_state_pkg::S_DONE;
      end
      autotest_state_pkg::S_START: begin
        start_uut_o    = 1'b1;
        ctrl_mux_uut_o = 1'b1;
        next_state     = autotest_state_pkg::S_RUN;
      end
      autotest_state_pkg::S_RUN: begin
        start_uut_o    = 1'b1;
        ctrl_mux_uut_o = 1'b1;
        timer_run_o    = 1'b1;
        if (end_uut_i || err_uut_i || timeout_i) begin
          next_state = autotest_state_pkg::S_END_RUN;
        end
      end
      autotest_state_pkg::S_END_RUN: begin
        ctrl_mux_uut_o = 1'b1;
        next_state     = autotest_state_pkg::S_STORE_RESULT;
      end
      autotest_state_pkg::S_STORE_RESULT: begin
        ctrl_mux_uut_o = 1'b1;
        result_store_o = 1'b1;
        idx_clr_o      = 1'b1;
        next_state     = autotest_state_pkg::S_WR_BLOCK;
      end
      autotest_state_pkg::S_WR_BLOCK: begin
        spi_w_block_o = 1'b1;
        if (spi_busy_i) next_state = autotest_state_pkg::S_WAIT_WR_BLOCK;
      end
      autotest_state_pkg::S_WAIT_WR_BLOCK: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) next_state = autotest_state_pkg::S_WR_DATA;
      end
      autotest_state_pkg::S_WR_DATA: begin
        // reloads each cycle, so the byte is settled before busy rises
        spi_w_block_o = 1'b1;
        spi_w_byte_o  = 1'b1;
        wdata_load_o  = 1'b1;
        if (spi_busy_i) next_state = autotest_state_pkg::S_WAIT_WR_BYTE;
      end
      autotest_state_pkg::S_WAIT_WR_BYTE: begin
        spi_w_block_o = 1'b1;
        if (!spi_busy_i) begin
          if (last_byte_i) begin
            next_state = autotest_state_pkg::S_NEXT_BLOCK;
          end else begin
            idx_inc_o  = 1'b1;
            next_state = autotest_state_pkg::S_WR_DATA;
          end
        end
      end
      autotest_state_pkg::S_NEXT_BLOCK: begin
        rst_uut_o  = 1'b1;
        blk_inc    = 1'b1;
        next_state = autotest_state_pkg::S_IDLE;
      end
      autotest_state_pkg::S_DONE: begin
        done_o = 1'b1;
      end
      default: begin
        next_state = autotest_state_pkg::S_INIT;
      end
    endcase
  end

endmodule

//--- src/autotest_state_pkg.sv
//##########################################################
// state encoding of the self-test sequencer FSM
//##########################################################

package autotest_state_pkg;

  localparam int STATE_W = 5;

  localparam logic [STATE_W-1:0] S_INIT          = 5'd0;
  localparam logic [STATE_W-1:0] S_SPI_RST       = 5'd1;
  localparam logic [STATE_W-1:0] S_WAIT_RST      = 5'd2;
  localparam logic [STATE_W-1:0] S_IDLE          = 5'd3;
  localparam logic [STATE_W-1:0] S_RD_BLOCK      = 5'd4;
  localparam logic [STATE_W-1:0] S_WAIT_RD_BLOCK = 5'd5;
  localparam logic [STATE_W-1:0] S_RD_DATA       = 5'd6;
  localparam logic [STATE_W-1:0] S_RD_BYTE       = 5'd7;
  localparam logic [STATE_W-1:0] S_WAIT_RD_BYTE  = 5'd8;
  localparam logic [STATE_W-1:0] S_CHECK_SIG     = 5'd9;
  localparam logic [STATE_W-1:0] S_START         = 5'd10;
  localparam logic [STATE_W-1:0] S_RUN           = 5'd11;
  localparam logic [STATE_W-1:0] S_END_RUN       = 5'd12;
  localparam logic [STATE_W-1:0] S_STORE_RESULT  = 5'd13;
  localparam logic [STATE_W-1:0] S_WR_BLOCK      = 5'd14;
  localparam logic [STATE_W-1:0] S_WAIT_WR_BLOCK = 5'd15;
  localparam logic [STATE_W-1:0] S_WR_DATA       = 5'd16;
  localparam logic [STATE_W-1:0] S_WAIT_WR_BYTE  = 5'd17;
  localparam logic [STATE_W-1:0] S_NEXT_BLOCK    = 5'd18;
  localparam logic [STATE_W-1:0] S_DONE          = 5'd19;

endpackage

//--- src/autotest_top.sv
//##########################################################
// top of the SD-card-driven UUT self-test sequencer.
// connects to an SD host core on one side, the UUT on the other.
//##########################################################

`timescale 1ns/10ps

module autotest_top (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 spi_busy_i,
  input  logic [7:0]                           spi_data_out_i,
  input  logic                                 err_uut_i,
  input  logic                                 end_uut_i,
  output logic [31:0]                          spi_block_addr_o,
  output logic                                 spi_r_block_o,
  output logic                                 spi_r_byte_o,
  output logic                                 spi_rst_o,
  output logic                                 spi_w_block_o,
  output logic                                 spi_w_byte_o,
  output logic [7:0]                           spi_data_in_o,
  output logic                                 rst_uut_o,
  output logic                                 start_uut_o,
  output logic                                 ctrl_mux_uut_o,
  output logic [autotest_cfg_pkg::IN_W-1:0]      uut_data_o,
  output logic [autotest_cfg_pkg::ERR_CNT_W-1:0] error_count_o,
  output logic                                 done_o
);

  logic idx_clr, idx_inc, mem_we;
  logic cap_clr, cap_en;
  logic timer_clr, timer_run;
  logic result_store, wdata_load;
  logic last_byte, sig_match, timeout;
  logic [autotest_cfg_pkg::BYTE_IDX_W-1:0] byte_idx;
  logic [autotest_cfg_pkg::TIME_W-1:0]     run_time;
  logic [7:0] mem_byte;

  autotest_fsm u_fsm (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy_i),
    .end_uut_i        (end_uut_i),
    .err_uut_i        (err_uut_i),
    .last_byte_i      (last_byte),
    .sig_match_i      (sig_match),
    .timeout_i        (timeout),
    .spi_rst_o        (spi_rst_o),
    .spi_r_block_o    (spi_r_block_o),
    .spi_r_byte_o     (spi_r_byte_o),
    .spi_w_block_o    (spi_w_block_o),
    .spi_w_byte_o     (spi_w_byte_o),
    .spi_block_addr_o (spi_block_addr_o),
    .rst_uut_o        (rst_uut_o),
    .start_uut_o      (start_uut_o),
    .ctrl_mux_uut_o   (ctrl_mux_uut_o),
    .done_o           (done_o),
    .idx_clr_o        (idx_clr),
    .idx_inc_o        (idx_inc),
    .mem_we_o         (mem_we),
    .cap_clr_o        (cap_clr),
    .cap_en_o         (cap_en),
    .timer_clr_o      (timer_clr),
    .timer_run_o      (timer_run),
    .result_store_o   (result_store),
    .wdata_load_o     (wdata_load)
  );

  run_timer u_timer (
    .clk         (clk),
    .timer_clr_i (timer_clr),
    .timer_run_i (timer_run),
    .time_o      (run_time),
    .timeout_o   (timeout)
  );

  block_buffer u_buffer (
    .clk         (clk),
    .idx_clr_i   (idx_clr),
    .idx_inc_i   (idx_inc),
    .mem_we_i    (mem_we),
    .wr_byte_i   (spi_data_out_i),
    .byte_idx_o  (byte_idx),
    .rd_byte_o   (mem_byte),
    .last_byte_o (last_byte)
  );

  test_vector_regs u_vectors (
    .clk         (clk),
    .cap_clr_i   (cap_clr),
    .cap_en_i    (cap_en),
    .byte_idx_i  (byte_idx),
    .byte_i      (spi_data_out_i),
    .uut_data_o  (uut_data_o),
    .sig_match_o (sig_match)
  );

  result_writer u_writer (
    .clk            (clk),
    .rst            (rst),
    .result_store_i (result_store),
    .err_uut_i      (err_uut_i),
    .timeout_i      (timeout),
    .time_i         (run_time),
    .byte_idx_i     (byte_idx),
    .mem_byte_i     (mem_byte),
    .wdata_load_i   (wdata_load),
    .spi_data_in_o  (spi_data_in_o),
    .error_count_o  (error_count_o)
  );

endmodule

//--- src/block_buffer.sv
//##########################################################
// one SD block of bytes, addressed by a running byte index.
// filled from the read stream, replayed for the write-back.
//##########################################################

`timescale 1ns/10ps

module block_buffer (
  input  logic                                  clk,
  input  logic                                  idx_clr_i,
  input  logic                                  idx_inc_i,
  input  logic                                  mem_we_i,
  input  logic [7:0]                            wr_byte_i,
  output logic [autotest_cfg_pkg::BYTE_IDX_W-1:0] byte_idx_o,
  output logic [7:0]                            rd_byte_o,
  output logic                                  last_byte_o
);

  logic [7:0] mem [autotest_cfg_pkg::BLOCK_BYTES];
  logic [autotest_cfg_pkg::BYTE_IDX_W-1:0] idx;

  always_ff @(posedge clk) begin
    if (idx_clr_i) begin
      idx <= '0;
    end else if (idx_inc_i) begin
      idx <= idx + 1'b1;
    end
  end

  // write at the old index on the increment edge
  always_ff @(posedge clk) begin
    if (mem_we_i) begin
      mem[idx] <= wr_byte_i;
    end
    rd_byte_o <= mem[idx];
  end

  assign last_byte_o = idx == autotest_cfg_pkg::BYTE_IDX_W'(autotest_cfg_pkg::BLOCK_BYTES - 1);
  assign byte_idx_o  = idx;

endmodule

//--- src/result_writer.sv
//##########################################################
// latches the run result and time, counts failed runs and
// chooses each byte sent back to the card on write-back.
//##########################################################

`timescale 1ns/10ps

module result_writer (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic                                  result_store_i,
  input  logic                                  err_uut_i,
  input  logic                                  timeout_i,
  input  logic [autotest_cfg_pkg::TIME_W-1:0]     time_i,
  input  logic [autotest_cfg_pkg::BYTE_IDX_W-1:0] byte_idx_i,
  input  logic [7:0]                            mem_byte_i,
  input  logic                                  wdata_load_i,
  output logic [7:0]                            spi_data_in_o,
  output logic [autotest_cfg_pkg::ERR_CNT_W-1:0]  error_count_o
);

  logic [8*autotest_cfg_pkg::RESULT_BYTES-1:0] result_q;
  logic [autotest_cfg_pkg::TIME_W-1:0]         time_q;
  logic [7:0] wr_byte;
  logic       fail;

  assign fail = err_uut_i | timeout_i;

  always_ff @(posedge clk) begin
    if (result_store_i) begin
      result_q <= {{(8*autotest_cfg_pkg::RESULT_BYTES-1){1'b0}}, fail};
      time_q   <= time_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      error_count_o <= '0;
    end else if (result_store_i && fail) begin
      error_count_o <= error_count_o + 1'b1;
    end
  end

  // result and time overlay the block copy
  always_comb begin
    if (byte_idx_i >= autotest_cfg_pkg::RESULT_OFS &&
        byte_idx_i < autotest_cfg_pkg::RESULT_OFS + autotest_cfg_pkg::RESULT_BYTES) begin
      wr_byte = result_q[8*(byte_idx_i-autotest_cfg_pkg::RESULT_OFS) +: 8];
    end else if (byte_idx_i >= autotest_cfg_pkg::TIME_OFS &&
                 byte_idx_i < autotest_cfg_pkg::TIME_OFS + autotest_cfg_pkg::TIME_W/8) begin
      wr_byte = time_q[8*(byte_idx_i-autotest_cfg_pkg::TIME_OFS) +: 8];
    end else begin
      wr_byte = mem_byte_i;
    end
  end

  always_ff @(posedge clk) begin
    if (wdata_load_i) begin
      spi_data_in_o <= wr_byte;
    end
  end

endmodule

//--- src/run_timer.sv
//##########################################################
// execution cycle counter of the UUT, cleared per block.
// stops and flags a timeout past the configured limit.
//##########################################################

`timescale 1ns/10ps

module run_timer (
  input  logic                              clk,
  input  logic                              timer_clr_i,
  input  logic                              timer_run_i,
  output logic [autotest_cfg_pkg::TIME_W-1:0] time_o,
  output logic                              timeout_o
);

  logic [autotest_cfg_pkg::TIME_W-1:0] count;

  // freezes at limit+1 once timed out
  always_ff @(posedge clk) begin
    if (timer_clr_i) begin
      count <= '0;
    end else if (timer_run_i && !timeout_o) begin
      count <= count + 1'b1;
    end
  end

  assign timeout_o = count > autotest_cfg_pkg::TIMEOUT_CYCLES;
  assign time_o    = count;

endmodule

//--- src/test_vector_regs.sv
//##########################################################
// picks the signature and the UUT input word out of the
// read stream by byte index. signature is checked here.
//##########################################################

`timescale 1ns/10ps

module test_vector_regs (
  input  logic                                  clk,
  input  logic                                  cap_clr_i,
  input  logic                                  cap_en_i,
  input  logic [autotest_cfg_pkg::BYTE_IDX_W-1:0] byte_idx_i,
  input  logic [7:0]                            byte_i,
  output logic [autotest_cfg_pkg::IN_W-1:0]       uut_data_o,
  output logic                                  sig_match_o
);

  logic [8*autotest_cfg_pkg::SIG_BYTES-1:0] sig_q;
  logic [autotest_cfg_pkg::IN_W-1:0]        in_q;
  logic in_sig;
  logic in_input;

  assign in_sig   = byte_idx_i < autotest_cfg_pkg::SIG_BYTES;
  assign in_input = byte_idx_i >= autotest_cfg_pkg::IN_OFS &&
                    byte_idx_i < autotest_cfg_pkg::IN_OFS + autotest_cfg_pkg::IN_BYTES;

  always_ff @(posedge clk) begin
    if (cap_clr_i) begin
      sig_q <= '0;
      in_q  <= '0;
    end else if (cap_en_i) begin
      // signature arrives msb first, input lsb first
      if (in_sig) begin
        sig_q[8*(autotest_cfg_pkg::SIG_BYTES-1-byte_idx_i) +: 8] <= byte_i;
      end
      if (in_input) begin
        in_q[8*(byte_idx_i-autotest_cfg_pkg::IN_OFS) +: 8] <= byte_i;
      end
    end
  end

  assign sig_match_o = sig_q == autotest_cfg_pkg::SIGNATURE;
  assign uut_data_o  = in_q;

endmodule

//--- testbench/autotest_vectors.txt
// signature  input_word  mode  delay, all hex
// mode 0: UUT ends, 1: UUT flags an error, 2: UUT hangs until timeout
aabbccdd 12345678 0 5
aabbccdd cafe0001 1 c
aabbccdd 00000000 0 1
aabbccdd deadbeef 2 0
aabbccdd 0badf00d 1 3
aabbccdd ffffffff 0 28
aabbccdd 13572468 2 0
aabbccd0 55aa55aa 0 4

//--- testbench/sd_card_model.sv
//##########################################################
// behavioral SD host for the testbench. serves block images
// in read order and records every written byte and address.
//##########################################################

`timescale 1ns/10ps

module sd_card_model #(
  parameter int BLOCKS = 8
) (
  input  logic        clk,
  input  logic        spi_rst_i,
  input  logic        spi_r_block_i,
  input  logic        spi_r_byte_i,
  input  logic        spi_w_block_i,
  input  logic        spi_w_byte_i,
  input  logic [31:0] spi_block_addr_i,
  input  logic [7:0]  spi_data_in_i,
  output logic        spi_busy_o,
  output logic [7:0]  spi_data_out_o
);

  logic [7:0]  image   [BLOCKS][autotest_cfg_pkg::BLOCK_BYTES];
  logic [7:0]  written [BLOCKS][autotest_cfg_pkg::BLOCK_BYTES];
  logic [31:0] rd_addr [BLOCKS];
  logic [31:0] wr_addr [BLOCKS];
  int reads_done;
  int writes_done;

  // busy for base to base+2 cycles, returns 1 ns after an edge
  task automatic hold_busy(input int base);
    int cycles;
    cycles = base + ($urandom % 3);
    #1 spi_busy_o = 1'b1;
    repeat (cycles) @(posedge clk);
    #1;
  endtask

  task automatic serve_read();
    int blk;
    int i;
    blk = reads_done;
    rd_addr[blk] = spi_block_addr_i;
    hold_busy(2);
    spi_busy_o = 1'b0;
    for (i = 0; i < autotest_cfg_pkg::BLOCK_BYTES; i++) begin
      do @(posedge clk); while (spi_r_byte_i !== 1'b1);
      hold_busy(1);
      // byte goes out with the busy fall
      spi_data_out_o = image[blk][i];
      spi_busy_o     = 1'b0;
    end
    reads_done++;
    do @(posedge clk); while (spi_r_block_i === 1'b1);
  endtask

  task automatic take_write();
    int blk;
    int i;
    blk = writes_done;
    wr_addr[blk] = spi_block_addr_i;
    hold_busy(2);
    spi_busy_o = 1'b0;
    for (i = 0; i < autotest_cfg_pkg::BLOCK_BYTES; i++) begin
      do @(posedge clk); while (spi_w_byte_i !== 1'b1);
      hold_busy(1);
      written[blk][i] = spi_data_in_i;
      spi_busy_o      = 1'b0;
    end
    writes_done++;
    do @(posedge clk); while (spi_w_block_i === 1'b1);
  endtask

  initial begin
    spi_busy_o     = 1'b0;
    spi_data_out_o = 8'h00;
    reads_done     = 0;
    writes_done    = 0;
    forever begin
      @(posedge clk);
      if (spi_rst_i === 1'b1) begin
        hold_busy(3);
        spi_busy_o = 1'b0;
      end else if (spi_r_block_i === 1'b1) begin
        serve_read();
      end else if (spi_w_block_i === 1'b1) begin
        take_write();
      end
    end
  end

endmodule

//--- testbench/tb_autotest.sv
//##########################################################
// testbench of the SD self-test sequencer. blocks built from
// the vector file are served by the card model, the UUT is
// modeled here, and each write-back is checked byte by byte.
//##########################################################

`timescale 1ns/10ps

module tb_autotest;

  localparam int NUM_VEC     = 8;
  localparam int CLK_PERIOD  = 4;
  localparam int SD_CYCLES   = 2 * autotest_cfg_pkg::BLOCK_BYTES * 8 + 64;
  localparam int WATCHDOG_NS = NUM_VEC * (autotest_cfg_pkg::TIMEOUT_CYCLES + SD_CYCLES)
                               * 2 * CLK_PERIOD;
  localparam int MODE_END    = 0;
  localparam int MODE_ERR    = 1;
  localparam int MODE_HANG   = 2;

  logic        clk;
  logic        rst;
  logic        spi_busy;
  logic [7:0]  spi_data_out;
  logic        err_uut;
  logic        end_uut;
  logic [31:0] spi_block_addr;
  logic        spi_r_block;
  logic        spi_r_byte;
  logic        spi_rst;
  logic        spi_w_block;
  logic        spi_w_byte;
  logic [7:0]  spi_data_in;
  logic        rst_uut;
  logic        start_uut;
  logic        ctrl_mux_uut;
  logic [autotest_cfg_pkg::IN_W-1:0]      uut_data;
  logic [autotest_cfg_pkg::ERR_CNT_W-1:0] error_count;
  logic        done;

  logic [31:0] vec [4*NUM_VEC];
  int errors;
  int checks;
  int fails_expected;
  int stray_strobes;
  logic done_seen;

  autotest_top dut (
    .clk              (clk),
    .rst              (rst),
    .spi_busy_i       (spi_busy),
    .spi_data_out_i   (spi_data_out),
    .err_uut_i        (err_uut),
    .end_uut_i        (end_uut),
    .spi_block_addr_o (spi_block_addr),
    .spi_r_block_o    (spi_r_block),
    .spi_r_byte_o     (spi_r_byte),
    .spi_rst_o        (spi_rst),
    .spi_w_block_o    (spi_w_block),
    .spi_w_byte_o     (spi_w_byte),
    .spi_data_in_o    (spi_data_in),
    .rst_uut_o        (rst_uut),
    .start_uut_o      (start_uut),
    .ctrl_mux_uut_o   (ctrl_mux_uut),
    .uut_data_o       (uut_data),
    .error_count_o    (error_count),
    .done_o           (done)
  );

  sd_card_model #(.BLOCKS(NUM_VEC)) card (
    .clk              (clk),
    .spi_rst_i        (spi_rst),
    .spi_r_block_i    (spi_r_block),
    .spi_r_byte_i     (spi_r_byte),
    .spi_w_block_i    (spi_w_block),
    .spi_w_byte_i     (spi_w_byte),
    .spi_block_addr_i (spi_block_addr),
    .spi_data_in_i    (spi_data_in),
    .spi_busy_o       (spi_busy),
    .spi_data_out_o   (spi_data_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // any SD strobe from the first cycle with done high on
  always @(posedge clk) begin
    if (done === 1'b1) begin
      done_seen = 1'b1;
    end
    if (done_seen &&
        (spi_rst | spi_r_block | spi_r_byte | spi_w_block | spi_w_byte) !== 1'b0) begin
      stray_strobes++;
    end
  end

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic check_block(input int b);
    logic [31:0] result;
    logic [63:0] run_time;
    int mode;
    int delay;
    int i;
    mode  = vec[4*b+2];
    delay = vec[4*b+3];
    check_value(card.rd_addr[b], autotest_cfg_pkg::START_BLOCK + b, "read block address");
    check_value(card.wr_addr[b], autotest_cfg_pkg::START_BLOCK + b, "write block address");
    for (i = 0; i < autotest_cfg_pkg::BLOCK_BYTES; i++) begin
      if (i >= autotest_cfg_pkg::RESULT_OFS && i < autotest_cfg_pkg::RESULT_OFS + 4) begin
        result[8*(i-autotest_cfg_pkg::RESULT_OFS) +: 8] = card.written[b][i];
      end else if (i >= autotest_cfg_pkg::TIME_OFS && i < autotest_cfg_pkg::TIME_OFS + 8) begin
        run_time[8*(i-autotest_cfg_pkg::TIME_OFS) +: 8] = card.written[b][i];
      end else begin
        check_value(card.written[b][i], card.image[b][i], $sformatf("copied byte %0d", i));
      end
    end
    check_value(result, mode != MODE_END, "result word");
    if (mode == MODE_HANG) begin
      check_value(run_time, autotest_cfg_pkg::TIMEOUT_CYCLES + 1, "time of a hung run");
    end else begin
      check_value(run_time >= delay && run_time <= delay + 3, 1,
                  $sformatf("time %0d for a delay of %0d", run_time, delay));
    end
  endtask

  // UUT model answering start after the vector's delay, held until write-back
  task automatic run_block(input int b);
    do @(posedge clk); while (start_uut !== 1'b1);
    check_value(uut_data, vec[4*b+1], "UUT input word");
    check_value(rst_uut, 0, "UUT reset while started");
    if (vec[4*b+2] != MODE_HANG) begin
      repeat (vec[4*b+3]) @(posedge clk);
      #1;
      end_uut = vec[4*b+2] == MODE_END;
      err_uut = vec[4*b+2] == MODE_ERR;
    end
    do @(posedge clk); while (card.writes_done <= b);
    #1;
    end_uut = 1'b0;
    err_uut = 1'b0;
    if (vec[4*b+2] != MODE_END) begin
      fails_expected++;
    end
    check_value(error_count, fails_expected, "error count");
    check_block(b);
  endtask

  task automatic stop_block(input int b);
    do @(posedge clk); while (done !== 1'b1);
    repeat (200) @(posedge clk);
    check_value(done, 1, "done held");
    check_value(stray_strobes, 0, "strobes after done");
    check_value(card.writes_done, b, "blocks written back");
    check_value(card.rd_addr[b], autotest_cfg_pkg::START_BLOCK + b, "read block address");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the sequencer did not get through all blocks in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    int b;
    int i;
    int err_before;
    int blocks_ok;
    int blocks_bad;
    int seed_val;
    logic stopped;
    clk            = 1'b0;
    rst            = 1'b1;
    err_uut        = 1'b0;
    end_uut        = 1'b0;
    errors         = 0;
    checks         = 0;
    fails_expected = 0;
    stray_strobes  = 0;
    done_seen      = 1'b0;
    blocks_ok      = 0;
    blocks_bad     = 0;
    stopped        = 1'b0;
    seed_val       = $urandom(32'h79f5_c60b);
    $readmemh("testbench/autotest_vectors.txt", vec);
    // random payload overlaid by the signature msb first and the input lsb first
    for (b = 0; b < NUM_VEC; b++) begin
      for (i = 0; i < autotest_cfg_pkg::BLOCK_BYTES; i++) begin
        card.image[b][i] = 8'($urandom);
      end
      for (i = 0; i < 4; i++) begin
        card.image[b][i] = vec[4*b][8*(3-i) +: 8];
        card.image[b][autotest_cfg_pkg::IN_OFS + i] = vec[4*b+1][8*i +: 8];
      end
    end
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
    check_value({spi_rst, spi_r_block, spi_r_byte, spi_w_block, spi_w_byte,
                 rst_uut, start_uut, ctrl_mux_uut, done}, 0, "control outputs after reset");
    for (b = 0; b < NUM_VEC && !stopped; b++) begin
      err_before = errors;
      if (vec[4*b] == autotest_cfg_pkg::SIGNATURE) begin
        run_block(b);
      end else begin
        stop_block(b);
        stopped = 1'b1;
      end
      if (errors == err_before) begin
        blocks_ok++;
        $display("block %0d: pass", b);
      end else begin
        blocks_bad++;
        $display("block %0d: %0d errors", b, errors - err_before);
      end
    end
    $display("%0d blocks, %0d passed, %0d failed, %0d checks, %0d errors",
             blocks_ok + blocks_bad, blocks_ok, blocks_bad, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
src/autotest_cfg_pkg.sv
src/autotest_state_pkg.sv
src/run_timer.sv
src/block_buffer.sv
src/test_vector_regs.sv
src/result_writer.sv
src/autotest_fsm.sv
src/autotest_top.sv
testbench/sd_card_model.sv
testbench/tb_autotest.sv
